//--- noc_config_pkg.sv
package noc_config_pkg;

  // ##############################
  // Network dimensions
  // ##############################

  // Input sides are x plus, x minus, y plus, y minus and local
  localparam int NOC_PORTS  = 5;
  localparam int NOC_VCS    = 2;
  localparam int NOC_VC_W   = 1;
  localparam int NOC_DATA_W = 32;

  // ##############################
  // Flit encoding
  // ##############################

  // Bit 0 marks the start of a packet and bit 1 marks its end
  typedef enum logic [1:0] {
    NOC_FLIT_BODY   = 2'b00,
    NOC_FLIT_HEAD   = 2'b01,
    NOC_FLIT_TAIL   = 2'b10,
    NOC_FLIT_SINGLE = 2'b11
  } noc_flit_type_e;

  typedef struct packed {
    noc_flit_type_e          flit_type;
    logic [NOC_DATA_W-1:0]   payload;
  } noc_flit_t;

  // One input side, with a lane per virtual channel
  typedef struct packed {
    logic [NOC_VCS-1:0]      valid;
    noc_flit_t [NOC_VCS-1:0] flit;
  } noc_port_bus_t;

  // Outgoing link, channels interleaved flit by flit
  typedef struct packed {
    logic                    valid;
    logic [NOC_VC_W-1:0]     vc;
    noc_flit_t               flit;
  } noc_link_flit_t;

  // ##############################
  // Flit helpers
  // ##############################

  function automatic logic noc_is_head(input noc_flit_type_e flit_type);
    return (flit_type == NOC_FLIT_HEAD) || (flit_type == NOC_FLIT_SINGLE);
  endfunction

  function automatic logic noc_is_tail(input noc_flit_type_e flit_type);
    return (flit_type == NOC_FLIT_TAIL) || (flit_type == NOC_FLIT_SINGLE);
  endfunction

  // A single flit opens and closes its packet in one go, so it never locks
  function automatic logic noc_opens_packet(input noc_flit_type_e flit_type);
    return noc_is_head(flit_type) && !noc_is_tail(flit_type);
  endfunction

endpackage

//--- noc_rr_arbiter.sv
`timescale 1ns/10ps

module noc_rr_arbiter #(
  parameter int REQUESTERS = 2
)(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [REQUESTERS-1:0] request,
  input  logic                  hold,
  input  logic                  advance,
  output logic [REQUESTERS-1:0] grant
);

  // One-hot priority pointer, the bit that is set has top priority
  logic [REQUESTERS-1:0] ptr_q;
  logic [REQUESTERS-1:0] grant_q;
  logic [REQUESTERS-1:0] upper_req;
  logic [REQUESTERS-1:0] rr_grant;

  // Requesters at or above the pointer win first, otherwise wrap around
  always_comb begin
    upper_req = request & ~(ptr_q - 1'b1);
    if (|upper_req) begin
      rr_grant = upper_req & (~upper_req + 1'b1);
    end else begin
      rr_grant = request & (~request + 1'b1);
    end
  end

  assign grant = hold ? grant_q : rr_grant;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr_q   <= REQUESTERS'(1);
      grant_q <= '0;
    end else if (advance && |grant) begin
      grant_q <= grant;
      // Move the pointer one place past the winner
      ptr_q   <= {grant[REQUESTERS-2:0], grant[REQUESTERS-1]};
    end
  end

endmodule

//--- noc_output_switch.sv
`timescale 1ns/10ps

module noc_output_switch
  import noc_config_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [NOC_PORTS-1:0]      in_valid,
  input  noc_flit_t [NOC_PORTS-1:0] in_flit,
  output logic [NOC_PORTS-1:0]      in_ready,
  output logic                      out_valid,
  output noc_flit_t                 out_flit,
  input  logic                      out_ready
);

  logic [NOC_PORTS-1:0] grant;
  logic                 lock_q;
  logic                 out_free;
  logic                 in_xfer;
  noc_flit_t            sel_flit;

  logic                 out_valid_q;
  noc_flit_t            out_flit_q;

  // ##############################
  // Input arbitration
  // ##############################

  // While a packet is open the arbiter keeps its grant on the owning port
  noc_rr_arbiter #(
    .REQUESTERS (NOC_PORTS)
  ) u_rr_arbiter (
    .clk      (clk      ),
    .rst_n    (rst_n    ),
    .request  (in_valid ),
    .hold     (lock_q   ),
    .advance  (in_xfer  ),
    .grant    (grant    )
  );

  // The register takes a new flit when empty or when it drains this cycle
  assign out_free = !out_valid_q || out_ready;

  assign in_ready = grant & {NOC_PORTS{out_free}};
  assign in_xfer  = |(in_valid & in_ready);

  // Grant is one-hot, so at most one lane is picked
  always_comb begin
    sel_flit = '0;
    for (int i = 0; i < NOC_PORTS; i++) begin
      if (grant[i]) begin
        sel_flit = in_flit[i];
      end
    end
  end

  // ##############################
  // Packet lock
  // ##############################

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lock_q <= 1'b0;
    end else if (in_xfer) begin
      if (noc_opens_packet(sel_flit.flit_type)) begin
        lock_q <= 1'b1;
      end else if (noc_is_tail(sel_flit.flit_type)) begin
        lock_q <= 1'b0;
      end
    end
  end

  // ##############################
  // Output register
  // ##############################

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid_q <= 1'b0;
    end else if (out_free) begin
      out_valid_q <= in_xfer;
    end
  end

  always_ff @(posedge clk) begin
    if (in_xfer) begin
      out_flit_q <= sel_flit;
    end
  end

  assign out_valid = out_valid_q;
  assign out_flit  = out_flit_q;

endmodule

//--- noc_channel_merger.sv
`timescale 1ns/10ps

module noc_channel_merger
  import noc_config_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [NOC_VCS-1:0]      in_valid,
  input  noc_flit_t [NOC_VCS-1:0] in_flit,
  output logic [NOC_VCS-1:0]      in_ready,
  output noc_link_flit_t          out_link,
  input  logic                    out_ready
);

  logic [NOC_VCS-1:0]  grant;
  logic                link_free;
  logic                in_xfer;
  logic [NOC_VC_W-1:0] win_vc;
  noc_flit_t           win_flit;

  logic                link_valid_q;
  logic [NOC_VC_W-1:0] link_vc_q;
  noc_flit_t           link_flit_q;

  // ##############################
  // Channel arbitration
  // ##############################

  // Channels may interleave, so the grant is never held across a packet
  noc_rr_arbiter #(
    .REQUESTERS (NOC_VCS)
  ) u_rr_arbiter (
    .clk      (clk      ),
    .rst_n    (rst_n    ),
    .request  (in_valid ),
    .hold     (1'b0     ),
    .advance  (in_xfer  ),
    .grant    (grant    )
  );

  assign link_free = !link_valid_q || out_ready;
  assign in_ready  = grant & {NOC_VCS{link_free}};
  assign in_xfer   = |(in_valid & in_ready);

  // Turn the one-hot grant into the channel index for the link
  always_comb begin
    win_vc   = '0;
    win_flit = '0;
    for (int i = 0; i < NOC_VCS; i++) begin
      if (grant[i]) begin
        win_vc   = NOC_VC_W'(i);
        win_flit = in_flit[i];
      end
    end
  end

  // ##############################
  // Link register
  // ##############################

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      link_valid_q <= 1'b0;
    end else if (link_free) begin
      link_valid_q <= in_xfer;
    end
  end

  always_ff @(posedge clk) begin
    if (in_xfer) begin
      link_vc_q   <= win_vc;
      link_flit_q <= win_flit;
    end
  end

  assign out_link.valid = link_valid_q;
  assign out_link.vc    = link_vc_q;
  assign out_link.flit  = link_flit_q;

endmodule

//--- noc_output_block.sv
`timescale 1ns/10ps

module noc_output_block
  import noc_config_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  noc_port_bus_t      in_x_plus,
  input  noc_port_bus_t      in_x_minus,
  input  noc_port_bus_t      in_y_plus,
  input  noc_port_bus_t      in_y_minus,
  input  noc_port_bus_t      in_local,
  output logic [NOC_VCS-1:0] ready_x_plus,
  output logic [NOC_VCS-1:0] ready_x_minus,
  output logic [NOC_VCS-1:0] ready_y_plus,
  output logic [NOC_VCS-1:0] ready_y_minus,
  output logic [NOC_VCS-1:0] ready_local,
  output noc_link_flit_t     out_link,
  input  logic               out_ready
);

  noc_port_bus_t [NOC_PORTS-1:0]           port_bus;
  logic [NOC_PORTS-1:0][NOC_VCS-1:0]       port_ready;

  logic [NOC_VCS-1:0]                      sw_valid;
  noc_flit_t [NOC_VCS-1:0]                 sw_flit;
  logic [NOC_VCS-1:0]                      sw_ready;

  // Port index order is x plus, x minus, y plus, y minus, local
  assign port_bus[0] = in_x_plus;
  assign port_bus[1] = in_x_minus;
  assign port_bus[2] = in_y_plus;
  assign port_bus[3] = in_y_minus;
  assign port_bus[4] = in_local;

  assign ready_x_plus  = port_ready[0];
  assign ready_x_minus = port_ready[1];
  assign ready_y_plus  = port_ready[2];
  assign ready_y_minus = port_ready[3];
  assign ready_local   = port_ready[4];

  for (genvar g_i = 0; g_i < NOC_VCS; g_i++) begin : g_channel
    logic [NOC_PORTS-1:0]      lane_valid;
    noc_flit_t [NOC_PORTS-1:0] lane_flit;
    logic [NOC_PORTS-1:0]      lane_ready;

    for (genvar g_j = 0; g_j < NOC_PORTS; g_j++) begin : g_port
      assign lane_valid[g_j]      = port_bus[g_j].valid[g_i];
      assign lane_flit[g_j]       = port_bus[g_j].flit[g_i];
      assign port_ready[g_j][g_i] = lane_ready[g_j];
    end

    noc_output_switch u_output_switch (
      .clk        (clk             ),
      .rst_n      (rst_n           ),
      .in_valid   (lane_valid      ),
      .in_flit    (lane_flit       ),
      .in_ready   (lane_ready      ),
      .out_valid  (sw_valid[g_i]   ),
      .out_flit   (sw_flit[g_i]    ),
      .out_ready  (sw_ready[g_i]   )
    );
  end

  noc_channel_merger u_channel_merger (
    .clk        (clk        ),
    .rst_n      (rst_n      ),
    .in_valid   (sw_valid   ),
    .in_flit    (sw_flit    ),
    .in_ready   (sw_ready   ),
    .out_link   (out_link   ),
    .out_ready  (out_ready  )
  );

endmodule

//--- noc_output_block_assert.sv
`timescale 1ns/10ps

module noc_output_block_assert
  import noc_config_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  noc_link_flit_t          out_link,
  input  logic                    out_ready,
  input  logic [NOC_VCS-1:0]      sw_valid,
  input  noc_flit_t [NOC_VCS-1:0] sw_flit,
  input  logic [NOC_VCS-1:0]      sw_ready
);

  // ##############################
  // Link handshake
  // ##############################

  // A stalled link flit keeps its valid and its contents
  property link_holds_p;
    @(posedge clk) disable iff (!rst_n)
      (out_link.valid && !out_ready) |=> (out_link.valid && $stable(out_link));
  endproperty

  link_holds_a : assert property (link_holds_p)
    else $error("link flit changed while out_ready was low");

  link_reset_a : assert property (@(posedge clk) !rst_n |=> !out_link.valid)
    else $error("link valid high in the cycle after reset");

  // ##############################
  // Switch to merger handshake
  // ##############################

  for (genvar g_i = 0; g_i < NOC_VCS; g_i++) begin : g_switch
    switch_holds_a : assert property (
      @(posedge clk) disable iff (!rst_n)
        (sw_valid[g_i] && !sw_ready[g_i]) |=> (sw_valid[g_i] && $stable(sw_flit[g_i])))
      else $error("switch %0d dropped its flit before the merger took it", g_i);
  end

endmodule

//--- noc_output_block_tb.sv
`timescale 1ns/10ps

module noc_output_block_tb
  import noc_config_pkg::*;
;

  localparam int CLK_PERIOD   = 4;
  localparam int DRIVE_DELAY  = 1;
  localparam int RESET_CYCLES = 4;
  localparam int SEED         = 77006;
  localparam int PACKETS      = 400;
  localparam int MAX_LEN      = 6;
  localparam int LANES        = NOC_PORTS * NOC_VCS;
  // Eight cycles per flit for the longest possible run
  localparam int WATCHDOG_NS  = LANES * PACKETS * MAX_LEN * 8 * CLK_PERIOD;
  // Cycles allowed for the flits still in flight to leave the link
  localparam int DRAIN_CYCLES = 100;

  logic                clk;
  logic                rst_n;
  logic                out_ready;
  logic                stim_start;
  noc_port_bus_t       in_bus [NOC_PORTS];
  logic [NOC_VCS-1:0]  ready_bus [NOC_PORTS];
  noc_link_flit_t      out_link;

  logic                src_valid [NOC_PORTS][NOC_VCS];
  noc_flit_t           src_flit [NOC_PORTS][NOC_VCS];

  // Reference model state
  noc_flit_t           model_q [NOC_PORTS][NOC_VCS][$];
  int                  owner [NOC_VCS];
  bit                  pkt_open [NOC_VCS];
  int                  rx_seq [NOC_PORTS][NOC_VCS];
  int                  sent;
  int                  received;
  int                  lanes_done;
  bit                  prev_stall;
  noc_link_flit_t      prev_link;

  noc_output_block i_noc_output_block (
    .clk           (clk          ),
    .rst_n         (rst_n        ),
    .in_x_plus     (in_bus[0]    ),
    .in_x_minus    (in_bus[1]    ),
    .in_y_plus     (in_bus[2]    ),
    .in_y_minus    (in_bus[3]    ),
    .in_local      (in_bus[4]    ),
    .ready_x_plus  (ready_bus[0] ),
    .ready_x_minus (ready_bus[1] ),
    .ready_y_plus  (ready_bus[2] ),
    .ready_y_minus (ready_bus[3] ),
    .ready_local   (ready_bus[4] ),
    .out_link      (out_link     ),
    .out_ready     (out_ready    )
  );

  bind noc_output_block noc_output_block_assert i_assert (
    .clk       (clk      ),
    .rst_n     (rst_n    ),
    .out_link  (out_link ),
    .out_ready (out_ready),
    .sw_valid  (sw_valid ),
    .sw_flit   (sw_flit  ),
    .sw_ready  (sw_ready )
  );

  always_comb begin
    for (int p = 0; p < NOC_PORTS; p++) begin
      for (int c = 0; c < NOC_VCS; c++) begin
        in_bus[p].valid[c] = src_valid[p][c];
        in_bus[p].flit[c]  = src_flit[p][c];
      end
    end
  end

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ##############################
  // Error reporting
  // ##############################

  task automatic value_error(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    $display("[ERROR] %s expected 0x%0h actual 0x%0h", name, expected, actual);
    $display("TB FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic protocol_error(input string msg);
    $display("Error: %s", msg);
    $display("TB FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_idle_ports(input string phase);
    assert (out_link.valid === 1'b0)
      else value_error({"out_link.valid ", phase}, 0, out_link.valid);
    for (int p = 0; p < NOC_PORTS; p++) begin
      assert (ready_bus[p] === '0)
        else value_error($sformatf("ready port %0d %s", p, phase), 0, ready_bus[p]);
    end
  endtask

  // ##############################
  // Link checker
  // ##############################

  task automatic check_link_flit(input noc_link_flit_t lf);
    int        c;
    int        p;
    int        hp;
    int        hc;
    logic      is_head;
    logic      is_tail;
    noc_flit_t expected;
    c       = lf.vc;
    is_head = (lf.flit.flit_type == NOC_FLIT_HEAD) || (lf.flit.flit_type == NOC_FLIT_SINGLE);
    is_tail = (lf.flit.flit_type == NOC_FLIT_TAIL) || (lf.flit.flit_type == NOC_FLIT_SINGLE);
    if (is_head) begin
      assert (!pkt_open[c])
        else protocol_error($sformatf("head flit on channel %0d inside an open packet", c));
      hp = lf.flit.payload[27:24];
      hc = lf.flit.payload[23:20];
      assert (hp < NOC_PORTS) else value_error("head port field", NOC_PORTS - 1, hp);
      assert (hc == c) else value_error("out_link.vc", hc, c);
      // Heads of one lane leave in the order they were sent
      assert (lf.flit.payload[15:0] == 16'(rx_seq[hp][c]))
        else value_error("head sequence", rx_seq[hp][c], lf.flit.payload[15:0]);
      rx_seq[hp][c]++;
      owner[c] = hp;
    end else begin
      assert (pkt_open[c])
        else protocol_error($sformatf("body or tail flit on idle channel %0d", c));
    end
    p = owner[c];
    assert (model_q[p][c].size() > 0)
      else protocol_error($sformatf("link flit with nothing pending on port %0d", p));
    expected = model_q[p][c].pop_front();
    assert (lf.flit === expected) else value_error("out_link.flit", expected, lf.flit);
    pkt_open[c] = is_head ? !is_tail : (pkt_open[c] && !is_tail);
    received++;
  endtask

  // Everything settles well before the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      for (int p = 0; p < NOC_PORTS; p++) begin
        for (int c = 0; c < NOC_VCS; c++) begin
          if (src_valid[p][c] && ready_bus[p][c]) begin
            model_q[p][c].push_back(src_flit[p][c]);
            sent++;
          end
        end
      end
      if (prev_stall) begin
        assert (out_link === prev_link) else value_error("out_link", prev_link, out_link);
      end
      if (out_link.valid && out_ready) begin
        check_link_flit(out_link);
      end
      prev_stall = out_link.valid && !out_ready;
      prev_link  = out_link;
    end
  end

  // ##############################
  // Packet sources
  // ##############################

  for (genvar g_p = 0; g_p < NOC_PORTS; g_p++) begin : g_src
    for (genvar g_c = 0; g_c < NOC_VCS; g_c++) begin : g_vc
      logic      lane_valid;
      noc_flit_t lane_flit;

      assign src_valid[g_p][g_c] = lane_valid;
      assign src_flit[g_p][g_c]  = lane_flit;

      initial begin : source
        int   len;
        int   gap;
        logic taken;
        lane_valid = 1'b0;
        lane_flit  = '0;
        wait (stim_start);
        for (int k = 0; k < PACKETS; k++) begin
          len = $urandom_range(MAX_LEN, 1);
          for (int f = 0; f < len; f++) begin
            if (len == 1) lane_flit.flit_type = NOC_FLIT_SINGLE;
            else if (f == 0) lane_flit.flit_type = NOC_FLIT_HEAD;
            else if (f == len - 1) lane_flit.flit_type = NOC_FLIT_TAIL;
            else lane_flit.flit_type = NOC_FLIT_BODY;
            // Head payload carries port, channel and sequence number
            if (f == 0) lane_flit.payload = {4'hA, 4'(g_p), 4'(g_c), 4'h0, 16'(k)};
            else lane_flit.payload = $urandom();
            lane_valid = 1'b1;
            do begin
              @(negedge clk);
              taken = ready_bus[g_p][g_c];
              @(posedge clk);
            end while (!taken);
            #DRIVE_DELAY;
            lane_valid = 1'b0;
            gap = ($urandom_range(3, 0) == 0) ? $urandom_range(4, 1) : 0;
            repeat (gap) begin
              @(posedge clk);
              #DRIVE_DELAY;
            end
          end
        end
        lanes_done++;
      end
    end
  end

  // Sink, ready roughly seven cycles in ten
  initial begin
    out_ready = 1'b0;
    wait (stim_start);
    forever begin
      @(posedge clk);
      #DRIVE_DELAY;
      out_ready = ($urandom_range(9, 0) < 7);
    end
  end

  initial begin
    #WATCHDOG_NS;
    $display("Timeout: the link stopped delivering flits before the run ended");
    $display("TB FAILED");
    $fatal(1, "watchdog expired");
  end

  // ##############################
  // Main sequence
  // ##############################

  initial begin
    int drain;
    void'($urandom(SEED));
    rst_n      = 1'b0;
    stim_start = 1'b0;
    sent       = 0;
    received   = 0;
    lanes_done = 0;
    prev_stall = 1'b0;
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk);
      #DRIVE_DELAY;
      check_idle_ports("during reset");
    end
    rst_n = 1'b1;
    repeat (2) begin
      @(negedge clk);
      check_idle_ports("after reset");
    end
    @(posedge clk);
    #DRIVE_DELAY;
    stim_start = 1'b1;

    wait (lanes_done == LANES);
    drain = 0;
    while ((received != sent) && (drain < DRAIN_CYCLES)) begin
      @(posedge clk);
      drain++;
    end

    for (int p = 0; p < NOC_PORTS; p++) begin
      for (int c = 0; c < NOC_VCS; c++) begin
        assert (model_q[p][c].size() == 0)
          else protocol_error($sformatf("flits of port %0d channel %0d were lost", p, c));
      end
    end
    for (int c = 0; c < NOC_VCS; c++) begin
      assert (!pkt_open[c])
        else protocol_error($sformatf("channel %0d ended inside a packet", c));
    end
    assert (received == sent) else value_error("received flit count", sent, received);
    $display("TB PASSED");
    $finish;
  end

endmodule

//--- filelist.f
noc_config_pkg.sv
noc_rr_arbiter.sv
noc_output_switch.sv
noc_channel_merger.sv
noc_output_block.sv
noc_output_block_assert.sv
noc_output_block_tb.sv

//--- Bender.yml
package:
  name: noc_output_block

sources:
  - files:
      - noc_config_pkg.sv
      - noc_rr_arbiter.sv
      - noc_output_switch.sv
      - noc_channel_merger.sv
      - noc_output_block.sv
  - target: test
    files:
      - noc_output_block_assert.sv
      - noc_output_block_tb.sv
